/* common/bch_pkg.sv */
package bch_pkg;

    // code geometry
    localparam int CODE_N = 15;
    localparam int MSG_K  = 7;

    localparam logic [8:0] GEN_POLY = 9'b111010001;   // x^8+x^7+x^6+x^4+1
    localparam logic [4:0] GF_POLY  = 5'b10011;       // x^4+x+1

    // field constants, alpha and its inverse powers
    localparam logic [3:0] ALPHA      = 4'h2;
    localparam logic [3:0] ALPHA_INV  = 4'h9;         // alpha^14
    localparam logic [3:0] ALPHA_INV2 = 4'hd;         // alpha^13

    // ------------------------------------------------------------------
    // register map
    // ------------------------------------------------------------------
    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;

    localparam logic [AXIL_ADDR_W-1:0] ADDR_DATA   = 4'h0;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_CTRL   = 4'h4;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS = 4'h8;
    localparam logic [AXIL_ADDR_W-1:0] ADDR_RESULT = 4'hc;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // corrector FSM encoding
    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_SYN_WAIT = 2'd1;
    localparam logic [1:0] ST_SEARCH   = 2'd2;
    localparam logic [1:0] ST_FINISH   = 2'd3;

    typedef logic [3:0] gf_elem_t;

    // one DATA word, read as a message in encode mode and as a received word in decode mode
    typedef union packed {
        logic [AXIL_DATA_W-1:0] raw;
        struct packed {
            logic [AXIL_DATA_W-MSG_K-1:0] pad;
            logic [MSG_K-1:0]             message;
        } msg;
        struct packed {
            logic [AXIL_DATA_W-CODE_N-1:0] pad;
            logic [CODE_N-1:0]             word;
        } cw;
    } bch_data_u;

    // ------------------------------------------------------------------
    // GF(16) arithmetic
    // ------------------------------------------------------------------
    function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
        logic [7:0] prod;
        prod = '0;
        for (int i = 0; i < 4; i++)
            if (b[i])
                prod ^= 8'(a) << i;      // carry-less product
        for (int i = 7; i >= 4; i--)
            if (prod[i])
                prod ^= 8'(GF_POLY) << (i - 4);
        return prod[3:0];
    endfunction

    function automatic gf_elem_t gf_cube(input gf_elem_t a);
        return gf_mul(a, gf_mul(a, a));
    endfunction

    // inverse table, zero maps to zero
    function automatic gf_elem_t gf_inv(input gf_elem_t a);
        case (a)
            4'h1: return 4'h1;
            4'h2: return 4'h9;
            4'h3: return 4'he;
            4'h4: return 4'hd;
            4'h5: return 4'hb;
            4'h6: return 4'h7;
            4'h7: return 4'h6;
            4'h8: return 4'hf;
            4'h9: return 4'h2;
            4'ha: return 4'hc;
            4'hb: return 4'h5;
            4'hc: return 4'ha;
            4'hd: return 4'h4;
            4'he: return 4'h3;
            4'hf: return 4'h8;
            default: return 4'h0;
        endcase
    endfunction

endpackage

/* common/bch_job_if.sv */
`timescale 1ns/10ps

// one codec job, issued by the register slave
interface bch_job_if;
    import bch_pkg::*;

    logic      start;    // single-cycle pulse
    logic      decode;   // 1 = decode, 0 = encode
    bch_data_u data;     // snapshot of DATA taken at start
    logic      busy;

    modport host  (output start, output decode, output data, input busy);
    modport codec (input start, input decode, input data, output busy);
    modport view  (input start, input decode, input data);

endinterface

/* common/bch_result_if.sv */
`timescale 1ns/10ps

// finished result going back to the register slave
interface bch_result_if;
    import bch_pkg::*;

    logic               done;            // one-cycle pulse
    logic [CODE_N-1:0]  codeword;
    logic [MSG_K-1:0]   message;
    logic [1:0]         err_count;
    logic               uncorrectable;

    modport former (output done, output codeword, output message);
    modport status (output err_count, output uncorrectable);
    modport view   (input done, input codeword, input message, input err_count,
                    input uncorrectable);

endinterface

/* rtl/axil_regs.sv */
`timescale 1ns/10ps

module axil_regs (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              awvalid,
    input  logic [bch_pkg::AXIL_ADDR_W-1:0]   awaddr,
    output logic                              awready,
    input  logic                              wvalid,
    input  logic [bch_pkg::AXIL_DATA_W-1:0]   wdata,
    input  logic [bch_pkg::AXIL_DATA_W/8-1:0] wstrb,
    output logic                              wready,
    output logic                              bvalid,
    output logic [1:0]                        bresp,
    input  logic                              bready,
    input  logic                              arvalid,
    input  logic [bch_pkg::AXIL_ADDR_W-1:0]   araddr,
    output logic                              arready,
    output logic                              rvalid,
    output logic [bch_pkg::AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]                        rresp,
    input  logic                              rready,
    bch_job_if.host                           job,
    bch_result_if.view                        result
);
    import bch_pkg::*;

    bch_data_u              data_reg;
    logic                   done_flag;       // sticky until next start
    logic [1:0]             err_count;
    logic                   uncorrectable;
    logic [CODE_N-1:0]      res_codeword;
    logic [MSG_K-1:0]       res_message;
    logic                   start_req;
    logic [AXIL_DATA_W-1:0] rd_mux;

    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;

    // start only from a CTRL write with bit 0 set while the codec is idle
    assign start_req = awready && (awaddr == ADDR_CTRL) && wstrb[0] && wdata[0] && !job.busy;

    // ------------------------------------------------------------------
    // write channel
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end
        else
        begin
            awready <= awvalid && wvalid && !awready && !bvalid;   // both together, one cycle
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (awready)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            data_reg   <= '0;
            job.start  <= 1'b0;
            job.decode <= 1'b0;
            job.data   <= '0;
        end
        else
        begin
            job.start <= start_req;
            if (awready && awaddr == ADDR_DATA)
            begin
                for (int b = 0; b < AXIL_DATA_W/8; b++)
                    if (wstrb[b])
                        data_reg.raw[8*b +: 8] <= wdata[8*b +: 8];
            end
            if (start_req)
            begin
                job.decode <= wdata[1];
                job.data   <= data_reg;   // job works on a frozen copy
            end
        end
    end

    // status and result capture
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            done_flag     <= 1'b0;
            err_count     <= '0;
            uncorrectable <= 1'b0;
            res_codeword  <= '0;
            res_message   <= '0;
        end
        else if (start_req)
            done_flag <= 1'b0;
        else if (result.done)
        begin
            done_flag     <= 1'b1;
            err_count     <= result.err_count;
            uncorrectable <= result.uncorrectable;
            res_codeword  <= result.codeword;
            res_message   <= result.message;
        end
    end

    // ------------------------------------------------------------------
    // read channel
    // ------------------------------------------------------------------
    always_comb
    begin
        case (araddr)
            ADDR_DATA:   rd_mux = data_reg.raw;
            ADDR_CTRL:   rd_mux = {30'b0, job.decode, 1'b0};
            ADDR_STATUS: rd_mux = {27'b0, uncorrectable, err_count, done_flag, job.busy};
            ADDR_RESULT: rd_mux = {9'b0, res_message, 1'b0, res_codeword};
            default:     rd_mux = '0;    // unmapped
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
        end
        else
        begin
            arready <= arvalid && !arready && !rvalid;
            if (arready)
            begin
                rvalid <= 1'b1;
                rdata  <= rd_mux;
            end
            else if (rready)
                rvalid <= 1'b0;
        end
    end

endmodule

/* bch/bch_syndrome.sv */
`timescale 1ns/10ps

module bch_syndrome (
    input  logic              clk,
    input  logic              rst,
    bch_job_if.view           job,
    output bch_pkg::gf_elem_t s1,
    output bch_pkg::gf_elem_t s3
);
    import bch_pkg::*;

    gf_elem_t s1_sum;
    gf_elem_t s3_sum;

    // r(alpha) and r(alpha^3), summing the powers of each set bit
    always_comb
    begin
        gf_elem_t pw;
        pw     = 4'h1;     // alpha^0
        s1_sum = '0;
        s3_sum = '0;
        for (int i = 0; i < CODE_N; i++)
        begin
            if (job.data.cw.word[i])
            begin
                s1_sum ^= pw;
                s3_sum ^= gf_cube(pw);   // (alpha^i)^3
            end
            pw = gf_mul(pw, ALPHA);
        end
    end

    // valid one cycle after start
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            s1 <= '0;
            s3 <= '0;
        end
        else if (job.start)
        begin
            s1 <= s1_sum;
            s3 <= s3_sum;
        end
    end

endmodule

/* bch/bch_corrector.sv */
`timescale 1ns/10ps

module bch_corrector (
    input  logic                         clk,
    input  logic                         rst,
    bch_job_if.codec                     job,
    input  bch_pkg::gf_elem_t            s1,
    input  bch_pkg::gf_elem_t            s3,
    output logic [bch_pkg::CODE_N-1:0]   fixed_word,
    output logic                         finish,
    bch_result_if.status                 result
);
    import bch_pkg::*;

    logic [1:0] state;
    logic [3:0] pos;          // bit position under test
    gf_elem_t   term1;        // sigma1 * alpha^-i
    gf_elem_t   term2;        // sigma2 * alpha^-2i
    logic [1:0] degree;       // locator degree
    logic [1:0] roots;
    logic [1:0] roots_next;
    gf_elem_t   s1_cube;
    gf_elem_t   sigma2;
    logic       hit;

    assign s1_cube    = gf_cube(s1);
    assign sigma2     = gf_mul(s3 ^ s1_cube, gf_inv(s1));   // (S3 + S1^3) / S1
    assign hit        = ((4'h1 ^ term1 ^ term2) == 4'h0);   // sigma(alpha^-i) == 0
    assign roots_next = roots + {1'b0, hit};

    assign job.busy = (state != ST_IDLE);
    assign finish   = (state == ST_FINISH);

    // ------------------------------------------------------------------
    // job FSM and Chien search
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state                <= ST_IDLE;
            pos                  <= '0;
            term1                <= '0;
            term2                <= '0;
            degree               <= '0;
            roots                <= '0;
            fixed_word           <= '0;
            result.err_count     <= '0;
            result.uncorrectable <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (job.start)
                    begin
                        fixed_word           <= job.data.cw.word;
                        result.err_count     <= '0;
                        result.uncorrectable <= 1'b0;
                        state                <= job.decode ? ST_SYN_WAIT : ST_FINISH;
                    end
                ST_SYN_WAIT:
                begin
                    // syndromes are valid here, classify them
                    pos    <= '0;
                    roots  <= '0;
                    term1  <= s1;
                    term2  <= sigma2;
                    degree <= (s3 == s1_cube) ? 2'd1 : 2'd2;
                    if (s1 == 4'h0)
                    begin
                        result.uncorrectable <= (s3 != 4'h0);   // S1 = 0, S3 != 0
                        state                <= ST_FINISH;
                    end
                    else
                        state <= ST_SEARCH;
                end
                ST_SEARCH:
                begin
                    if (hit)
                        fixed_word[pos] <= ~fixed_word[pos];
                    term1 <= gf_mul(term1, ALPHA_INV);
                    term2 <= gf_mul(term2, ALPHA_INV2);
                    roots <= roots_next;
                    pos   <= pos + 4'd1;
                    if (pos == CODE_N - 1)
                    begin
                        if (roots_next == degree)
                            result.err_count <= roots_next;
                        else
                            result.uncorrectable <= 1'b1;   // locator does not split
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH:
                    state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* rtl/bch_result_former.sv */
`timescale 1ns/10ps

module bch_result_former (
    input  logic                        clk,
    input  logic                        rst,
    bch_job_if.view                     job,
    input  logic [bch_pkg::CODE_N-1:0]  fixed_word,
    input  logic                        finish,
    bch_result_if.former                result
);
    import bch_pkg::*;

    logic [CODE_N-1:0] enc_word;
    logic [MSG_K-1:0]  dec_msg;

    // message x g(x)
    always_comb
    begin
        enc_word = '0;
        for (int i = 0; i < MSG_K; i++)
            if (job.data.msg.message[i])
                enc_word ^= CODE_N'(GEN_POLY) << i;
    end

    // long division by g(x), only the quotient is kept
    always_comb
    begin
        logic [CODE_N-1:0] rem;
        rem     = fixed_word;
        dec_msg = '0;
        for (int i = CODE_N - 1; i >= CODE_N - MSG_K; i--)
        begin
            if (rem[i])
            begin
                dec_msg[i - (CODE_N - MSG_K)] = 1'b1;
                rem ^= CODE_N'(GEN_POLY) << (i - (CODE_N - MSG_K));
            end
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            result.done <= 1'b0;
        else
            result.done <= finish;   // one cycle behind the corrector
    end

    always_ff @(posedge clk)
    begin
        if (finish)
        begin
            result.codeword <= job.decode ? fixed_word : enc_word;
            result.message  <= job.decode ? dec_msg : job.data.msg.message;
        end
    end

endmodule

/* rtl/bch_top.sv */
`timescale 1ns/10ps

module bch_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              awvalid,
    input  logic [bch_pkg::AXIL_ADDR_W-1:0]   awaddr,
    output logic                              awready,
    input  logic                              wvalid,
    input  logic [bch_pkg::AXIL_DATA_W-1:0]   wdata,
    input  logic [bch_pkg::AXIL_DATA_W/8-1:0] wstrb,
    output logic                              wready,
    output logic                              bvalid,
    output logic [1:0]                        bresp,
    input  logic                              bready,
    input  logic                              arvalid,
    input  logic [bch_pkg::AXIL_ADDR_W-1:0]   araddr,
    output logic                              arready,
    output logic                              rvalid,
    output logic [bch_pkg::AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]                        rresp,
    input  logic                              rready
);
    import bch_pkg::*;

    gf_elem_t          s1;
    gf_elem_t          s3;
    logic [CODE_N-1:0] fixed_word;
    logic              finish;

    bch_job_if    job_if ();
    bch_result_if result_if ();

    // ------------------------------------------------------------------
    // register slave, then codec, then result
    // ------------------------------------------------------------------
    axil_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awaddr  (awaddr),
        .awready (awready),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bready  (bready),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rready  (rready),
        .job     (job_if.host),
        .result  (result_if.view)
    );

    bch_syndrome u_syndrome (
        .clk (clk),
        .rst (rst),
        .job (job_if.view),
        .s1  (s1),
        .s3  (s3)
    );

    bch_corrector u_corrector (
        .clk        (clk),
        .rst        (rst),
        .job        (job_if.codec),
        .s1         (s1),
        .s3         (s3),
        .fixed_word (fixed_word),
        .finish     (finish),
        .result     (result_if.status)
    );

    bch_result_former u_former (
        .clk        (clk),
        .rst        (rst),
        .job        (job_if.view),
        .fixed_word (fixed_word),
        .finish     (finish),
        .result     (result_if.former)
    );

endmodule

/* tb/bch_assertions.sv */
`timescale 1ns/10ps

module bch_assertions (
    input logic       clk,
    input logic       rst,
    input logic       start,
    input logic       busy,
    input logic [1:0] err_count
);

    // syndrome wait, 15 search cycles and finish at most
    busy_bounded: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> ##[1:17] !busy)
        else $error("busy held longer than 17 cycles");

    err_limit: assert property (@(posedge clk) disable iff (rst)
        err_count <= 2'd2)
        else $error("error count above two");

    no_start_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy)   // regs must filter it
        else $error("start issued while busy");

endmodule

bind bch_corrector bch_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .start     (job.start),
    .busy      (job.busy),
    .err_count (result.err_count)
);

/* tb/tb_bch.sv */
`timescale 1ns/10ps

module tb_bch;
    import bch_pkg::*;

    localparam logic [8:0] GEN     = 9'b111010001;   // g(x) for the reference
    localparam int         CLK_P   = 20;
    localparam int         JOBS    = 200;
    localparam int         JOB_CYC = 40;

    logic        clk;
    logic        rst;
    logic        awvalid;
    logic [3:0]  awaddr;
    logic        awready;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        bready;
    logic        arvalid;
    logic [3:0]  araddr;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rready;

    int          errors = 0;
    int          checks = 0;
    int          done_count = 0;
    int          max_gap = 0;      // longest bready/rready stall
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];
    string       name_q[$];
    logic [31:0] cmp_exp;
    logic [31:0] cmp_act;
    string       cmp_name;

    bch_top UUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_P/2) clk = ~clk;
    end

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    function automatic logic [14:0] ref_encode(input logic [6:0] msg);
        logic [14:0] cw;
        cw = '0;
        for (int i = 0; i < 7; i++)
            if (msg[i])
                cw ^= 15'(GEN) << i;     // carry-less product
        return cw;
    endfunction

    function automatic logic [31:0] ref_result(input logic [6:0] msg);
        return {9'b0, msg, 1'b0, ref_encode(msg)};
    endfunction

    function automatic logic [31:0] ref_status(input int nerr, input logic unc);
        return {27'b0, unc, 2'(nerr), 1'b1, 1'b0};   // done set, busy clear
    endfunction

    // flip n distinct random bit positions
    function automatic logic [14:0] add_errors(input logic [14:0] cw, input int n);
        logic [14:0] mask;
        int          p;
        mask = '0;
        while ($countones(mask) < n)
        begin
            p = $urandom_range(14, 0);
            mask[p] = 1'b1;
        end
        return cw ^ mask;
    endfunction

    task automatic report_failure(input string what);
        $display("%0t: %s", $time, what);
        errors++;
    endtask

    // queue one observed value for the compare process
    task automatic queue_compare(input logic [31:0] expected, input logic [31:0] actual,
                                 input string name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
        name_q.push_back(name);
    endtask

    // ------------------------------------------------------------------
    // AXI-lite driver tasks start and end on a falling edge
    // ------------------------------------------------------------------
    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
        int n;
        int gap;
        n       = 0;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!(awready && wready) && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (n >= 20)
            report_failure("write address and data were never accepted");
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        gap     = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
        repeat (gap)
        begin
            if (!bvalid)
                report_failure("bvalid dropped before bready was raised");
            queue_compare({30'b0, RESP_OKAY}, {30'b0, bresp}, "bresp");
            @(negedge clk);
        end
        if (!bvalid)
            report_failure("no write response when bready was raised");
        queue_compare({30'b0, RESP_OKAY}, {30'b0, bresp}, "bresp");
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        if (bvalid)
            report_failure("bvalid still high after bready");
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
        int n;
        int gap;
        n       = 0;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (n >= 20)
            report_failure("read address was never accepted");
        @(negedge clk);
        arvalid = 1'b0;
        data    = rdata;
        gap     = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
        repeat (gap)
        begin
            if (!rvalid)
                report_failure("rvalid dropped before rready was raised");
            queue_compare(data, rdata, "rdata while rready low");
            @(negedge clk);
        end
        if (!rvalid)
            report_failure("no read response when rready was raised");
        queue_compare({30'b0, RESP_OKAY}, {30'b0, rresp}, "rresp");
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        if (rvalid)
            report_failure("rvalid still high after rready");
    endtask

    task automatic check_read(input logic [3:0] addr, input logic [31:0] expected,
                              input logic [31:0] mask, input string name);
        logic [31:0] got;
        axil_read(addr, got);
        queue_compare(expected & mask, got & mask, name);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int          n;
        st = '0;
        n  = 0;
        while (!st[1] && n < 40)
        begin
            axil_read(ADDR_STATUS, st);
            n++;
        end
        if (!st[1])
            report_failure("job never reported done in STATUS");
    endtask

    task automatic run_encode(input logic [6:0] msg);
        axil_write(ADDR_DATA, {25'b0, msg});
        axil_write(ADDR_CTRL, 32'h1);
        wait_done();
        check_read(ADDR_RESULT, ref_result(msg), '1, "RESULT");
        check_read(ADDR_STATUS, ref_status(0, 1'b0), '1, "STATUS");
    endtask

    task automatic run_decode(input logic [6:0] msg, input int nflip);
        logic [14:0] rx;
        rx = add_errors(ref_encode(msg), nflip);
        axil_write(ADDR_DATA, {17'b0, rx});
        axil_write(ADDR_CTRL, 32'h3);   // start in decode mode
        wait_done();
        check_read(ADDR_RESULT, ref_result(msg), '1, "RESULT");
        check_read(ADDR_STATUS, ref_status(nflip, 1'b0), '1, "STATUS");
    endtask

    // compare every queued observation with its expected value
    always
    begin
        wait (act_q.size() > 0);
        cmp_exp  = exp_q.pop_front();
        cmp_act  = act_q.pop_front();
        cmp_name = name_q.pop_front();
        checks++;
        if (cmp_act !== cmp_exp)
        begin
            $display("** Error at %0t: %s expected %h, got %h",
                     $time, cmp_name, cmp_exp, cmp_act);
            errors++;
        end
    end

    always @(negedge clk)
        if (UUT.result_if.done === 1'b1)
            done_count++;

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial
    begin
        logic [6:0]  msg;
        logic [14:0] rx;
        int          base;
        void'($urandom(32'ha0a55a17));
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = 4'hf;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        queue_compare(32'h0, {27'b0, awready, wready, bvalid, arready, rvalid},
                      "awready,wready,bvalid,arready,rvalid after reset");
        check_read(ADDR_STATUS, 32'h0, '1, "STATUS after reset");

        for (int i = 0; i < 30; i++)
            run_encode(7'($urandom));
        for (int i = 0; i < 45; i++)
            run_decode(7'($urandom), i % 3);   // 0, 1 or 2 flips

        // S1 = 0 and S3 != 0 for bits 0, 5 and 10
        msg = 7'($urandom);
        rx  = ref_encode(msg) ^ 15'h0421;
        axil_write(ADDR_DATA, {17'b0, rx});
        axil_write(ADDR_CTRL, 32'h3);
        wait_done();
        check_read(ADDR_STATUS, 32'h10, 32'h10, "STATUS.uncorrectable");

        // second start lands while the decode job is busy
        msg  = 7'($urandom);
        rx   = add_errors(ref_encode(msg), 1);
        base = done_count;
        axil_write(ADDR_DATA, {17'b0, rx});
        axil_write(ADDR_CTRL, 32'h3);
        axil_write(ADDR_CTRL, 32'h1);
        wait_done();
        check_read(ADDR_RESULT, ref_result(msg), '1, "RESULT");
        check_read(ADDR_STATUS, ref_status(1, 1'b0), '1, "STATUS");
        repeat (30) @(negedge clk);
        queue_compare(32'(base + 1), 32'(done_count), "done pulse count");

        max_gap = 6;
        for (int i = 0; i < 10; i++)
        begin
            msg = 7'($urandom);
            run_encode(msg);
            check_read(ADDR_DATA, {25'b0, msg}, '1, "DATA");
            run_decode(7'($urandom), 2);
        end

        @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // watchdog
    initial
    begin
        #(JOBS * JOB_CYC * CLK_P);
        $display("watchdog timeout, the run did not finish in time");
        $display("test failed");
        $finish;
    end

endmodule

/* tb.f */
common/bch_pkg.sv
common/bch_job_if.sv
common/bch_result_if.sv
rtl/axil_regs.sv
bch/bch_syndrome.sv
bch/bch_corrector.sv
rtl/bch_result_former.sv
rtl/bch_top.sv
tb/bch_assertions.sv
tb/tb_bch.sv

/* Bender.yml */
package:
  name: bch_codec

sources:
  - common/bch_pkg.sv
  - common/bch_job_if.sv
  - common/bch_result_if.sv
  - rtl/axil_regs.sv
  - bch/bch_syndrome.sv
  - bch/bch_corrector.sv
  - rtl/bch_result_former.sv
  - rtl/bch_top.sv
  - target: test
    files:
      - tb/bch_assertions.sv
      - tb/tb_bch.sv
